/* hw/layer_ctrl_pkg.sv */
package layer_ctrl_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------

  // Weight SRAM word address
  localparam int SRAM_ADDR_W = 12;
  // Channel counts and tile indices
  localparam int CHAN_W = 16;
  // Performance counters
  localparam int CTR_W = 32;

  typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;
  typedef logic [CHAN_W-1:0]      chan_t;
  typedef logic [CTR_W-1:0]       ctr_t;

  // ----------------------------------------------------------------------
  // Error codes
  // ----------------------------------------------------------------------

  typedef logic [1:0] err_code_t;

  localparam err_code_t ERR_NONE     = 2'd0;
  // Watchdog expired with no forward progress
  localparam err_code_t ERR_TIMEOUT  = 2'd1;
  // Channel count zero or not a whole number of tiles
  localparam err_code_t ERR_BAD_DESC = 2'd2;

  // ----------------------------------------------------------------------
  // State machines
  // ----------------------------------------------------------------------

  // Layer level, one pass per descriptor
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_LOAD_DESC,
    SEQ_LOAD_WEIGHTS,
    SEQ_ISSUE,
    SEQ_WAIT_DONE,
    SEQ_DONE
  } seq_state_t;

  // Tile level, one pass per command
  typedef enum logic [2:0] {
    EX_IDLE,
    EX_PRELOAD,
    EX_COMPUTE,
    EX_DRAIN,
    EX_QUANT,
    EX_STORE
  } exec_state_t;

endpackage

/* hw/tile_sequencer.sv */
`timescale 1ns/1ps

module tile_sequencer #(
  parameter int ARRAY_ROWS      = 8,
  parameter int ARRAY_COLS      = 8,
  parameter int WATCHDOG_CYCLES = 4096
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  logic                       abort_req,
  input  logic                       desc_valid,
  input  layer_ctrl_pkg::chan_t      desc_in_channels,
  input  layer_ctrl_pkg::chan_t      desc_out_channels,
  input  logic                       wgt_load_done,
  input  logic                       cmd_full,
  input  logic                       tile_done_last,
  input  logic                       exec_progress,
  output logic                       desc_ready,
  output logic                       wgt_load_start,
  output logic                       cmd_push,
  output layer_ctrl_pkg::sram_addr_t cmd_base,
  output logic                       cmd_first_ic,
  output logic                       cmd_last_ic,
  output logic                       cmd_last_tile,
  output logic                       flush,
  output logic                       busy,
  output logic                       done,
  output logic                       timeout,
  output logic                       error_flag,
  output layer_ctrl_pkg::err_code_t  error_code
);

  localparam int WD_W = $clog2(WATCHDOG_CYCLES + 1);

  layer_ctrl_pkg::seq_state_t state_q;
  layer_ctrl_pkg::seq_state_t state_d;

  // Tile totals taken from the accepted descriptor
  layer_ctrl_pkg::chan_t ic_total;
  layer_ctrl_pkg::chan_t oc_total;
  // Loop position, input channel is the inner loop
  layer_ctrl_pkg::chan_t ic_idx;
  layer_ctrl_pkg::chan_t oc_idx;
  logic [2*layer_ctrl_pkg::CHAN_W-1:0] tile_lin;

  logic            desc_xfer;
  logic            desc_ok;
  logic            last_ic;
  logic            last_oc;
  logic            progress;
  logic [WD_W-1:0] wd_cnt;

  // ----------------------------------------------------------------------
  // Descriptor check and tile addressing
  // ----------------------------------------------------------------------

  assign desc_ready = (state_q == layer_ctrl_pkg::SEQ_LOAD_DESC);
  assign desc_xfer  = desc_valid && desc_ready;

  // Both counts non-zero and whole tiles
  assign desc_ok = (desc_in_channels != '0) && (desc_in_channels % ARRAY_COLS == 0) &&
                   (desc_out_channels != '0) && (desc_out_channels % ARRAY_ROWS == 0);

  assign last_ic = (ic_idx == ic_total - 1'b1);
  assign last_oc = (oc_idx == oc_total - 1'b1);

  // Weights laid out output-major, ARRAY_ROWS words per tile
  assign tile_lin      = oc_idx * ic_total + ic_idx;
  assign cmd_base      = layer_ctrl_pkg::sram_addr_t'(tile_lin * ARRAY_ROWS);
  assign cmd_first_ic  = (ic_idx == '0);
  assign cmd_last_ic   = last_ic;
  assign cmd_last_tile = last_ic && last_oc;
  // One command per cycle until the FIFO fills
  assign cmd_push      = (state_q == layer_ctrl_pkg::SEQ_ISSUE) && !cmd_full;

  // ----------------------------------------------------------------------
  // Layer FSM
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      layer_ctrl_pkg::SEQ_IDLE, layer_ctrl_pkg::SEQ_DONE: begin
        if (start)
          state_d = layer_ctrl_pkg::SEQ_LOAD_DESC;
      end
      layer_ctrl_pkg::SEQ_LOAD_DESC: begin
        // Bad descriptor goes straight back to idle
        if (desc_xfer)
          state_d = desc_ok ? layer_ctrl_pkg::SEQ_LOAD_WEIGHTS : layer_ctrl_pkg::SEQ_IDLE;
      end
      layer_ctrl_pkg::SEQ_LOAD_WEIGHTS: begin
        if (wgt_load_done)
          state_d = layer_ctrl_pkg::SEQ_ISSUE;
      end
      layer_ctrl_pkg::SEQ_ISSUE: begin
        if (cmd_push && cmd_last_tile)
          state_d = layer_ctrl_pkg::SEQ_WAIT_DONE;
      end
      layer_ctrl_pkg::SEQ_WAIT_DONE: begin
        // Last tile retires once its output is taken
        if (tile_done_last)
          state_d = layer_ctrl_pkg::SEQ_DONE;
      end
      default: state_d = layer_ctrl_pkg::SEQ_IDLE;
    endcase
    // Timeout or abort wins over everything
    if (flush)
      state_d = layer_ctrl_pkg::SEQ_IDLE;
  end

  assign busy = (state_q != layer_ctrl_pkg::SEQ_IDLE) && (state_q != layer_ctrl_pkg::SEQ_DONE);
  assign done = (state_q == layer_ctrl_pkg::SEQ_DONE);

  // Watchdog, any state change, push or executor step is progress
  assign progress = (state_d != state_q) || cmd_push || exec_progress;
  assign timeout  = busy && (wd_cnt == WD_W'(WATCHDOG_CYCLES));
  assign flush    = timeout || abort_req;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= layer_ctrl_pkg::SEQ_IDLE;
      wgt_load_start <= 1'b0;
      ic_idx         <= '0;
      oc_idx         <= '0;
      wd_cnt         <= '0;
      error_flag     <= 1'b0;
      error_code     <= layer_ctrl_pkg::ERR_NONE;
    end else begin
      state_q <= state_d;
      // Single pulse on the first weight-load cycle
      wgt_load_start <= (state_d == layer_ctrl_pkg::SEQ_LOAD_WEIGHTS) &&
                        (state_q != layer_ctrl_pkg::SEQ_LOAD_WEIGHTS);

      // Tile walk restarts while weights load
      if (state_q == layer_ctrl_pkg::SEQ_LOAD_WEIGHTS) begin
        ic_idx <= '0;
        oc_idx <= '0;
      end else if (cmd_push) begin
        if (last_ic) begin
          ic_idx <= '0;
          oc_idx <= oc_idx + 1'b1;
        end else begin
          ic_idx <= ic_idx + 1'b1;
        end
      end

      if (!busy || progress)
        wd_cnt <= '0;
      else
        wd_cnt <= wd_cnt + 1'b1;

      // Error register, abort records nothing
      if (start && !busy) begin
        error_flag <= 1'b0;
        error_code <= layer_ctrl_pkg::ERR_NONE;
      end else if (timeout) begin
        error_flag <= 1'b1;
        error_code <= layer_ctrl_pkg::ERR_TIMEOUT;
      end else if (desc_xfer && !desc_ok) begin
        error_flag <= 1'b1;
        error_code <= layer_ctrl_pkg::ERR_BAD_DESC;
      end
    end
  end

  // Totals only matter after a good descriptor
  always_ff @(posedge clk) begin
    if (desc_xfer) begin
      ic_total <= layer_ctrl_pkg::chan_t'(desc_in_channels / ARRAY_COLS);
      oc_total <= layer_ctrl_pkg::chan_t'(desc_out_channels / ARRAY_ROWS);
    end
  end

endmodule

/* hw/tile_cmd_fifo.sv */
`timescale 1ns/1ps

module tile_cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       push,
  input  logic                       pop,
  input  layer_ctrl_pkg::sram_addr_t base_in,
  input  logic                       first_ic_in,
  input  logic                       last_ic_in,
  input  logic                       last_tile_in,
  output layer_ctrl_pkg::sram_addr_t base_out,
  output logic                       first_ic_out,
  output logic                       last_ic_out,
  output logic                       last_tile_out,
  output logic                       full,
  output logic                       empty
);

  localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
  // Base address plus three flags
  localparam int ENTRY_W = layer_ctrl_pkg::SRAM_ADDR_W + 3;

  logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // Drop every queued command
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push && !flush)
      mem[wr_ptr] <= {base_in, first_ic_in, last_ic_in, last_tile_in};
  end

  // Head is only meaningful while not empty
  assign {base_out, first_ic_out, last_ic_out, last_tile_out} = mem[rd_ptr];

endmodule

/* hw/tile_executor.sv */
`timescale 1ns/1ps

module tile_executor #(
  parameter int ARRAY_ROWS   = 8,
  parameter int DRAIN_CYCLES = 10
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush,
  input  logic                       cmd_empty,
  input  layer_ctrl_pkg::sram_addr_t cmd_base,
  input  logic                       cmd_first_ic,
  input  logic                       cmd_last_ic,
  input  logic                       cmd_last_tile,
  input  logic                       out_accepted,
  output logic                       cmd_pop,
  output logic                       sram_rd_en,
  output layer_ctrl_pkg::sram_addr_t sram_rd_addr,
  output logic                       array_enable,
  output logic                       array_clear_acc,
  output logic                       array_data_valid,
  output logic                       quant_enable,
  output logic                       out_valid,
  output logic                       out_last,
  output logic                       tile_done,
  output logic                       tile_done_last,
  output logic                       exec_progress,
  output logic                       compute_active,
  output logic                       store_stall
);

  // Two extra compute cycles cover the SRAM read latency
  localparam int COMPUTE_CYCLES = ARRAY_ROWS + 2;
  localparam int CNT_W          = $clog2(COMPUTE_CYCLES + DRAIN_CYCLES + 1);
  localparam int RD_W           = $clog2(ARRAY_ROWS + 1);

  layer_ctrl_pkg::exec_state_t state_q;
  layer_ctrl_pkg::exec_state_t state_d;

  logic [CNT_W-1:0] cyc_cnt;
  logic [RD_W-1:0]  rd_cnt;
  logic             compute_end;
  logic             drain_end;

  // Command latched at pop
  layer_ctrl_pkg::sram_addr_t base_q;
  logic                       first_ic_q;
  logic                       last_ic_q;
  logic                       last_tile_q;

  assign compute_end = (cyc_cnt == CNT_W'(COMPUTE_CYCLES - 1));
  assign drain_end   = (cyc_cnt == CNT_W'(DRAIN_CYCLES - 1));
  assign cmd_pop     = (state_q == layer_ctrl_pkg::EX_IDLE) && !cmd_empty && !flush;

  // ----------------------------------------------------------------------
  // Tile FSM
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      layer_ctrl_pkg::EX_IDLE: begin
        if (cmd_pop)
          state_d = layer_ctrl_pkg::EX_PRELOAD;
      end
      layer_ctrl_pkg::EX_PRELOAD: state_d = layer_ctrl_pkg::EX_COMPUTE;
      layer_ctrl_pkg::EX_COMPUTE: begin
        if (compute_end)
          state_d = layer_ctrl_pkg::EX_DRAIN;
      end
      layer_ctrl_pkg::EX_DRAIN: begin
        // Partial sums stay in the array until the last input tile
        if (drain_end)
          state_d = last_ic_q ? layer_ctrl_pkg::EX_QUANT : layer_ctrl_pkg::EX_IDLE;
      end
      layer_ctrl_pkg::EX_QUANT: state_d = layer_ctrl_pkg::EX_STORE;
      layer_ctrl_pkg::EX_STORE: begin
        if (out_accepted)
          state_d = layer_ctrl_pkg::EX_IDLE;
      end
      default: state_d = layer_ctrl_pkg::EX_IDLE;
    endcase
    if (flush)
      state_d = layer_ctrl_pkg::EX_IDLE;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= layer_ctrl_pkg::EX_IDLE;
      cyc_cnt <= '0;
      rd_cnt  <= '0;
    end else begin
      state_q <= state_d;
      // Cycle count restarts in every state
      if (state_d != state_q)
        cyc_cnt <= '0;
      else
        cyc_cnt <= cyc_cnt + 1'b1;
      if (cmd_pop)
        rd_cnt <= '0;
      else if (sram_rd_en)
        rd_cnt <= rd_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      base_q      <= cmd_base;
      first_ic_q  <= cmd_first_ic;
      last_ic_q   <= cmd_last_ic;
      last_tile_q <= cmd_last_tile;
    end
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------

  // Reads start one cycle early in preload
  assign sram_rd_en   = ((state_q == layer_ctrl_pkg::EX_PRELOAD) ||
                         (state_q == layer_ctrl_pkg::EX_COMPUTE)) &&
                        (rd_cnt < RD_W'(ARRAY_ROWS));
  assign sram_rd_addr = base_q + layer_ctrl_pkg::sram_addr_t'(rd_cnt);

  assign array_clear_acc  = (state_q == layer_ctrl_pkg::EX_PRELOAD) && first_ic_q;
  assign array_data_valid = (state_q == layer_ctrl_pkg::EX_COMPUTE);
  assign array_enable     = (state_q == layer_ctrl_pkg::EX_COMPUTE) ||
                            (state_q == layer_ctrl_pkg::EX_DRAIN);
  assign quant_enable     = (state_q == layer_ctrl_pkg::EX_QUANT) ||
                            (state_q == layer_ctrl_pkg::EX_STORE);

  assign out_valid = (state_q == layer_ctrl_pkg::EX_STORE);
  assign out_last  = out_valid && last_tile_q;

  // Retire after drain, or after the output handshake
  assign tile_done      = ((state_q == layer_ctrl_pkg::EX_DRAIN) && drain_end && !last_ic_q) ||
                          (out_valid && out_accepted);
  assign tile_done_last = tile_done && last_tile_q;
  assign exec_progress  = (state_d != state_q);
  assign compute_active = array_data_valid;
  assign store_stall    = out_valid && !out_accepted;

endmodule

/* hw/perf_counters.sv */
`timescale 1ns/1ps

module perf_counters (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  busy,
  input  logic                  compute_active,
  input  logic                  store_stall,
  input  logic                  tile_done,
  input  logic                  timeout,
  output layer_ctrl_pkg::ctr_t  ctr_cycles,
  output layer_ctrl_pkg::ctr_t  ctr_compute,
  output layer_ctrl_pkg::ctr_t  ctr_stall,
  output layer_ctrl_pkg::ctr_t  ctr_tiles,
  output layer_ctrl_pkg::ctr_t  ctr_errors
);

  localparam int NUM_CTR = 5;

  layer_ctrl_pkg::ctr_t ctr [NUM_CTR];
  logic [NUM_CTR-1:0]   event_hit;

  // Index 0 counts every busy cycle
  assign event_hit = {timeout, tile_done, store_stall, compute_active, 1'b1};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CTR; i++)
        ctr[i] <= '0;
    end else if (start && !busy) begin
      // New layer, fresh statistics
      for (int i = 0; i < NUM_CTR; i++)
        ctr[i] <= '0;
    end else if (busy) begin
      for (int i = 0; i < NUM_CTR; i++)
        if (event_hit[i])
          ctr[i] <= ctr[i] + 1'b1;
    end
  end

  assign ctr_cycles  = ctr[0];
  assign ctr_compute = ctr[1];
  assign ctr_stall   = ctr[2];
  assign ctr_tiles   = ctr[3];
  assign ctr_errors  = ctr[4];

endmodule

/* hw/layer_ctrl_top.sv */
`timescale 1ns/1ps

module layer_ctrl_top #(
  parameter int ARRAY_ROWS      = 8,
  parameter int ARRAY_COLS      = 8,
  parameter int DRAIN_CYCLES    = 10,
  parameter int FIFO_DEPTH      = 4,
  parameter int WATCHDOG_CYCLES = 4096
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  logic                       abort_req,
  output logic                       busy,
  output logic                       done,
  input  logic                       desc_valid,
  input  layer_ctrl_pkg::chan_t      desc_in_channels,
  input  layer_ctrl_pkg::chan_t      desc_out_channels,
  output logic                       desc_ready,
  output logic                       wgt_load_start,
  input  logic                       wgt_load_done,
  output logic                       sram_rd_en,
  output layer_ctrl_pkg::sram_addr_t sram_rd_addr,
  output logic                       array_enable,
  output logic                       array_clear_acc,
  output logic                       array_data_valid,
  output logic                       quant_enable,
  output logic                       out_valid,
  output logic                       out_last,
  input  logic                       out_accepted,
  output logic                       error_flag,
  output layer_ctrl_pkg::err_code_t  error_code,
  output layer_ctrl_pkg::ctr_t       ctr_cycles,
  output layer_ctrl_pkg::ctr_t       ctr_compute,
  output layer_ctrl_pkg::ctr_t       ctr_stall,
  output layer_ctrl_pkg::ctr_t       ctr_tiles,
  output layer_ctrl_pkg::ctr_t       ctr_errors
);

  // ----------------------------------------------------------------------
  // Sequencer to FIFO to executor
  // ----------------------------------------------------------------------

  logic                       cmd_push;
  logic                       cmd_pop;
  logic                       cmd_full;
  logic                       cmd_empty;
  logic                       flush;
  layer_ctrl_pkg::sram_addr_t push_base;
  logic                       push_first_ic;
  logic                       push_last_ic;
  logic                       push_last_tile;
  layer_ctrl_pkg::sram_addr_t head_base;
  logic                       head_first_ic;
  logic                       head_last_ic;
  logic                       head_last_tile;

  // Executor status
  logic tile_done;
  logic tile_done_last;
  logic exec_progress;
  logic compute_active;
  logic store_stall;
  logic timeout;

  tile_sequencer #(
    .ARRAY_ROWS      (ARRAY_ROWS),
    .ARRAY_COLS      (ARRAY_COLS),
    .WATCHDOG_CYCLES (WATCHDOG_CYCLES)
  ) u_seq (
    .clk, .rst_n, .start, .abort_req, .desc_valid, .desc_in_channels, .desc_out_channels,
    .wgt_load_done, .cmd_full, .tile_done_last, .exec_progress, .desc_ready,
    .wgt_load_start, .cmd_push, .cmd_base(push_base), .cmd_first_ic(push_first_ic),
    .cmd_last_ic(push_last_ic), .cmd_last_tile(push_last_tile), .flush, .busy, .done,
    .timeout, .error_flag, .error_code
  );

  tile_cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk, .rst_n, .flush, .push(cmd_push), .pop(cmd_pop), .base_in(push_base),
    .first_ic_in(push_first_ic), .last_ic_in(push_last_ic), .last_tile_in(push_last_tile),
    .base_out(head_base), .first_ic_out(head_first_ic), .last_ic_out(head_last_ic),
    .last_tile_out(head_last_tile), .full(cmd_full), .empty(cmd_empty)
  );

  tile_executor #(
    .ARRAY_ROWS   (ARRAY_ROWS),
    .DRAIN_CYCLES (DRAIN_CYCLES)
  ) u_exec (
    .clk, .rst_n, .flush, .cmd_empty, .cmd_base(head_base), .cmd_first_ic(head_first_ic),
    .cmd_last_ic(head_last_ic), .cmd_last_tile(head_last_tile), .out_accepted, .cmd_pop,
    .sram_rd_en, .sram_rd_addr, .array_enable, .array_clear_acc, .array_data_valid,
    .quant_enable, .out_valid, .out_last, .tile_done, .tile_done_last, .exec_progress,
    .compute_active, .store_stall
  );

  perf_counters u_perf (
    .clk, .rst_n, .start, .busy, .compute_active, .store_stall, .tile_done, .timeout,
    .ctr_cycles, .ctr_compute, .ctr_stall, .ctr_tiles, .ctr_errors
  );

endmodule

/* sim/layer_ctrl_assertions.sv */
`timescale 1ns/1ps

module layer_ctrl_assertions (
  input logic clk,
  input logic rst_n,
  input logic abort_req,
  input logic out_valid,
  input logic out_accepted,
  input logic error_flag,
  input logic desc_ready,
  input logic sram_rd_en,
  input logic done,
  input logic busy
);

  // Output held until taken, only a timeout or abort may drop it
  property out_valid_held;
    @(posedge clk) disable iff (!rst_n)
      out_valid && !out_accepted && !abort_req |=> out_valid || error_flag;
  endproperty

  // No weight reads while a descriptor is being taken
  property desc_excludes_reads;
    @(posedge clk) disable iff (!rst_n) !(desc_ready && sram_rd_en);
  endproperty

  property done_excludes_busy;
    @(posedge clk) disable iff (!rst_n) !(done && busy);
  endproperty

  assert property (out_valid_held) else $error("out_valid dropped before out_accepted");
  assert property (desc_excludes_reads) else $error("desc_ready and sram_rd_en both high");
  assert property (done_excludes_busy) else $error("done and busy both high");

endmodule

bind layer_ctrl_top layer_ctrl_assertions u_assertions (
  .clk, .rst_n, .abort_req, .out_valid, .out_accepted, .error_flag,
  .desc_ready, .sram_rd_en, .done, .busy
);

/* sim/layer_ctrl_tb.sv */
`timescale 1ns/1ps

module layer_ctrl_tb;

  localparam int ROWS     = 4;
  localparam int COLS     = 4;
  localparam int DRAIN    = 3;
  localparam int DEPTH    = 2;
  localparam int WD_LIMIT = 64;
  localparam int CLK_HALF = 20;
  localparam int unsigned SEED = 93742;

  // Selectors for await_high
  localparam int SEL_DESC_READY = 0;
  localparam int SEL_WGT_START  = 1;
  localparam int SEL_DONE       = 2;
  localparam int SEL_IDLE       = 3;

  logic                       clk;
  logic                       rst_n;
  logic                       start;
  logic                       abort_req;
  logic                       busy;
  logic                       done;
  logic                       desc_valid;
  layer_ctrl_pkg::chan_t      desc_in_channels;
  layer_ctrl_pkg::chan_t      desc_out_channels;
  logic                       desc_ready;
  logic                       wgt_load_start;
  logic                       wgt_load_done;
  logic                       sram_rd_en;
  layer_ctrl_pkg::sram_addr_t sram_rd_addr;
  logic                       array_enable;
  logic                       array_clear_acc;
  logic                       array_data_valid;
  logic                       quant_enable;
  logic                       out_valid;
  logic                       out_last;
  logic                       out_accepted;
  logic                       error_flag;
  layer_ctrl_pkg::err_code_t  error_code;
  layer_ctrl_pkg::ctr_t       ctr_cycles;
  layer_ctrl_pkg::ctr_t       ctr_compute;
  layer_ctrl_pkg::ctr_t       ctr_stall;
  layer_ctrl_pkg::ctr_t       ctr_tiles;
  layer_ctrl_pkg::ctr_t       ctr_errors;

  int          error_count;
  int          check_count;
  int unsigned wgt_rng;
  int unsigned acc_rng;
  logic        hold_accept;
  // Current descriptor and what the monitor has seen of it
  int          cur_in;
  int          cur_out;
  int          rd_beat;
  int          rd_tile;
  int          out_beats;
  int          clear_pulses;
  int          stall_seen;
  // Cycle counts of the array and quantizer strobes
  int          valid_cycles;
  int          enable_cycles;
  int          quant_cycles;
  int          busy_cycles;
  int          wgt_pulses;

  layer_ctrl_top #(
    .ARRAY_ROWS      (ROWS),
    .ARRAY_COLS      (COLS),
    .DRAIN_CYCLES    (DRAIN),
    .FIFO_DEPTH      (DEPTH),
    .WATCHDOG_CYCLES (WD_LIMIT)
  ) uut (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Weight base of tile k, output channel outer, input channel inner
  function automatic int expected_base(input int in_ch, input int k);
    int ic_tiles;
    int oc_idx;
    int ic_idx;
    ic_tiles = in_ch / COLS;
    if (ic_tiles == 0)
      return 0;
    oc_idx = k / ic_tiles;
    ic_idx = k % ic_tiles;
    return (oc_idx * ic_tiles + ic_idx) * ROWS;
  endfunction

  function automatic logic sig_value(input int sel);
    case (sel)
      SEL_DESC_READY: return desc_ready;
      SEL_WGT_START:  return wgt_load_start;
      SEL_DONE:       return done;
      default:        return !busy;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // Drive point, 2 ns past the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic await_high(input int sel, input int limit, input string what);
    int n;
    n = 0;
    while (!sig_value(sel) && n < limit) begin
      step_cycle();
      n++;
    end
    if (!sig_value(sel)) begin
      error_count++;
      $display("Timed out after %0d cycles waiting for %s", limit, what);
      finish_run();
    end
  endtask

  // Start pulse, then one descriptor transfer
  task automatic start_layer(input int in_ch, input int out_ch);
    cur_in        = in_ch;
    cur_out       = out_ch;
    rd_beat       = 0;
    rd_tile       = 0;
    out_beats     = 0;
    clear_pulses  = 0;
    stall_seen    = 0;
    valid_cycles  = 0;
    enable_cycles = 0;
    quant_cycles  = 0;
    busy_cycles   = 0;
    wgt_pulses    = 0;
    start         = 1'b1;
    step_cycle();
    start             = 1'b0;
    desc_valid        = 1'b1;
    desc_in_channels  = layer_ctrl_pkg::chan_t'(in_ch);
    desc_out_channels = layer_ctrl_pkg::chan_t'(out_ch);
    await_high(SEL_DESC_READY, 4, "desc_ready");
    step_cycle();
    desc_valid = 1'b0;
  endtask

  // Weight load answered after a random delay
  task automatic load_weights();
    int delay;
    await_high(SEL_WGT_START, 4, "wgt_load_start");
    wgt_rng = lcg_step(wgt_rng);
    delay   = (wgt_rng >> 16) % 8;
    repeat (delay) step_cycle();
    wgt_load_done = 1'b1;
    step_cycle();
    wgt_load_done = 1'b0;
  endtask

  task automatic run_clean(input int in_ch, input int out_ch);
    int ic_tiles;
    int oc_tiles;
    int tiles;
    ic_tiles = in_ch / COLS;
    oc_tiles = out_ch / ROWS;
    tiles    = ic_tiles * oc_tiles;
    start_layer(in_ch, out_ch);
    load_weights();
    await_high(SEL_DONE, 2000, "done");
    check_value("busy", 0, busy);
    check_value("sram read runs", tiles, rd_tile);
    check_value("out beats", oc_tiles, out_beats);
    check_value("array_clear_acc pulses", oc_tiles, clear_pulses);
    check_value("wgt_load_start pulses", 1, wgt_pulses);
    // Compute is ROWS+2 cycles per tile, then the drain
    check_value("array_data_valid cycles", tiles * (ROWS + 2), valid_cycles);
    check_value("array_enable cycles", tiles * (ROWS + 2 + DRAIN), enable_cycles);
    // One quantize cycle plus the store cycles of each output tile
    check_value("quant_enable cycles", 2 * oc_tiles + stall_seen, quant_cycles);
    check_value("ctr_tiles", tiles, ctr_tiles);
    check_value("ctr_compute", tiles * (ROWS + 2), ctr_compute);
    check_value("ctr_cycles", busy_cycles, ctr_cycles);
    check_value("ctr_stall", stall_seen, ctr_stall);
    check_value("ctr_errors", 0, ctr_errors);
    check_value("error_flag", 0, error_flag);
    check_value("error_code", layer_ctrl_pkg::ERR_NONE, error_code);
  endtask

  // ----------------------------------------------------------------------
  // Comparing process, sampled mid cycle
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    if (rst_n) begin
      if (sram_rd_en) begin
        if (rd_tile >= (cur_in / COLS) * (cur_out / ROWS)) begin
          error_count++;
          $display("More weight read runs than tiles in the layer");
        end else begin
          check_value("sram_rd_addr", expected_base(cur_in, rd_tile) + rd_beat, sram_rd_addr);
        end
        rd_beat++;
        if (rd_beat == ROWS) begin
          rd_beat = 0;
          rd_tile++;
        end
      end else if (rd_beat != 0) begin
        error_count++;
        $display("sram_rd_en dropped after %0d of %0d reads", rd_beat, ROWS);
        rd_beat = 0;
      end
      if (array_clear_acc)
        clear_pulses++;
      if (array_data_valid)
        valid_cycles++;
      if (array_enable)
        enable_cycles++;
      if (quant_enable)
        quant_cycles++;
      if (busy)
        busy_cycles++;
      if (wgt_load_start)
        wgt_pulses++;
      // Output back-pressure cycles
      if (out_valid && !out_accepted)
        stall_seen++;
      if (out_valid && out_accepted) begin
        out_beats++;
        check_value("out_last", out_beats == cur_out / ROWS, out_last);
      end
    end
  end

  // Output side, random back-pressure unless held off
  initial begin : accept_driver
    int wait_cycles;
    acc_rng      = SEED;
    out_accepted = 1'b0;
    forever begin
      step_cycle();
      out_accepted = 1'b0;
      if (rst_n && out_valid && !hold_accept) begin
        acc_rng     = lcg_step(acc_rng);
        wait_cycles = (acc_rng >> 16) % 4;
        repeat (wait_cycles) step_cycle();
        if (out_valid && !hold_accept)
          out_accepted = 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    rst_n             = 1'b0;
    start             = 1'b0;
    abort_req         = 1'b0;
    desc_valid        = 1'b0;
    desc_in_channels  = '0;
    desc_out_channels = '0;
    wgt_load_done     = 1'b0;
    hold_accept       = 1'b0;
    error_count       = 0;
    check_count       = 0;
    wgt_rng           = SEED;
    cur_in            = 0;
    cur_out           = 0;
    rd_beat           = 0;
    rd_tile           = 0;
    out_beats         = 0;
    clear_pulses      = 0;
    stall_seen        = 0;
    valid_cycles      = 0;
    enable_cycles     = 0;
    quant_cycles      = 0;
    busy_cycles       = 0;
    wgt_pulses        = 0;

    repeat (8) @(posedge clk);
    #2;
    // Quiet outputs while reset is held
    check_value("busy", 0, busy);
    check_value("done", 0, done);
    check_value("desc_ready", 0, desc_ready);
    check_value("sram_rd_en", 0, sram_rd_en);
    check_value("out_valid", 0, out_valid);
    check_value("error_flag", 0, error_flag);
    check_value("error_code", layer_ctrl_pkg::ERR_NONE, error_code);
    check_value("ctr_cycles", 0, ctr_cycles);
    check_value("ctr_tiles", 0, ctr_tiles);
    rst_n = 1'b1;
    step_cycle();

    run_clean(8, 8);
    run_clean(16, 4);
    run_clean(4, 12);

    // 6 input channels is not a whole tile
    start_layer(6, 8);
    await_high(SEL_IDLE, 8, "busy to drop after a bad descriptor");
    check_value("error_flag", 1, error_flag);
    check_value("error_code", layer_ctrl_pkg::ERR_BAD_DESC, error_code);

    // Output never taken, watchdog must fire
    hold_accept = 1'b1;
    start_layer(8, 8);
    load_weights();
    await_high(SEL_IDLE, 400, "watchdog timeout");
    check_value("error_flag", 1, error_flag);
    check_value("error_code", layer_ctrl_pkg::ERR_TIMEOUT, error_code);
    check_value("ctr_errors", 1, ctr_errors);
    check_value("done", 0, done);
    check_value("out_valid", 0, out_valid);
    hold_accept = 1'b0;
    step_cycle();

    run_clean(8, 8);
    finish_run();
  end

endmodule

/* layer_ctrl.f */
hw/layer_ctrl_pkg.sv
hw/tile_sequencer.sv
hw/tile_cmd_fifo.sv
hw/tile_executor.sv
hw/perf_counters.sv
hw/layer_ctrl_top.sv
sim/layer_ctrl_assertions.sv
sim/layer_ctrl_tb.sv
